// File: rtl/icache_cfg_pkg.sv
//**************************************************************************
// icache geometry: direct mapped, 16 sets of 16-byte lines, 32-bit address
//**************************************************************************
`default_nettype none

package icache_cfg_pkg;

  localparam int ADDR_W     = 32;
  localparam int LINE_BYTES = 16;
  localparam int SETS       = 16;

  // address split: tag | index | byte offset
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int INDEX_W  = $clog2(SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;  // 24 bits
  localparam int LINE_W   = 8 * LINE_BYTES;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [LINE_W-1:0]  line_t;

endpackage : icache_cfg_pkg

`default_nettype wire

// File: rtl/icache_msg_pkg.sv
//**************************************************************************
// icache messages toward l0, toward the LLC and between internal stages
//**************************************************************************
`default_nettype none

package icache_msg_pkg;

  import icache_cfg_pkg::*;

  // fetch from l0, byte address
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  // whole line back to l0
  typedef struct packed {
    logic [ADDR_W-1:0] addr;  // line aligned
    line_t             line;
  } fetch_resp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;  // line aligned
  } fill_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    line_t             line;
  } fill_resp_t;

  // decoded request handed from decode to control
  typedef struct packed {
    logic              flush;  // set for a flush, fields below unused then
    tag_t              tag;
    index_t            index;
    logic [ADDR_W-1:0] addr;
  } lookup_t;

endpackage : icache_msg_pkg

`default_nettype wire

// File: rtl/icache_req_decode.sv
//**************************************************************************
// icache request decode: one-entry buffer for fetch and flush requests
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module icache_req_decode
  import icache_cfg_pkg::*, icache_msg_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_N_in,
  input  logic       fetch_req_valid,
  output logic       fetch_req_ready,
  input  fetch_req_t fetch_req,
  input  logic       flush_valid,
  output logic       flush_ready,
  output logic       lk_valid,
  input  logic       lk_ready,
  output lookup_t    lk
);

  lookup_t buf_q;
  logic    buf_valid;
  logic    take_flush;
  logic    take_fetch;
  tag_t    req_tag;
  index_t  req_index;

  // flush wins when both arrive together
  assign flush_ready     = !buf_valid;
  assign fetch_req_ready = !buf_valid && !flush_valid;
  assign take_flush      = flush_valid && flush_ready;
  assign take_fetch      = fetch_req_valid && fetch_req_ready;

  assign req_tag   = fetch_req.addr[ADDR_W-1 -: TAG_W];
  assign req_index = fetch_req.addr[OFFSET_W +: INDEX_W];  // byte offset is dropped

  assign lk_valid = buf_valid;
  assign lk       = buf_q;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      buf_valid <= 1'b0;
    end else if (take_flush || take_fetch) begin
      buf_valid <= 1'b1;
    end else if (lk_ready) begin
      buf_valid <= 1'b0;  // taken by control
    end
  end

  always_ff @(posedge clk_in) begin
    if (take_flush) begin
      buf_q <= '{flush: 1'b1, tag: '0, index: '0, addr: '0};
    end else if (take_fetch) begin
      buf_q <= '{flush: 1'b0, tag: req_tag, index: req_index,
                 addr: {req_tag, req_index, {OFFSET_W{1'b0}}}};
    end
  end

endmodule : icache_req_decode

`default_nettype wire

// File: rtl/icache_tag_data_array.sv
//**************************************************************************
// icache storage: per-set valid bit, tag and line, synchronous read
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module icache_tag_data_array
  import icache_cfg_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_N_in,
  // read port, result one cycle later
  input  index_t rd_index,
  output logic   rd_hit_valid,
  output tag_t   rd_tag,
  output line_t  rd_line,
  // refill write
  input  logic   wr_en,
  input  index_t wr_index,
  input  tag_t   wr_tag,
  input  line_t  wr_line,
  input  logic   flush
);

  logic [SETS-1:0] valid_q;
  tag_t            tag_mem  [SETS];
  line_t           line_mem [SETS];

  // valid bits are the only state that must come up clean
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= '0;  // whole cache at once
    end else if (wr_en) begin
      valid_q[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      tag_mem[wr_index]  <= wr_tag;
      line_mem[wr_index] <= wr_line;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      rd_hit_valid <= 1'b0;
    end else begin
      rd_hit_valid <= valid_q[rd_index];
    end
  end

  // a same-cycle write to the read set returns the old contents
  always_ff @(posedge clk_in) begin
    rd_tag  <= tag_mem[rd_index];
    rd_line <= line_mem[rd_index];
  end

endmodule : icache_tag_data_array

`default_nettype wire

// File: rtl/icache_lookup_ctrl.sv
//**************************************************************************
// icache lookup control: hit/miss check, line fill and flush sequencing
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module icache_lookup_ctrl
  import icache_cfg_pkg::*, icache_msg_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_N_in,
  input  logic        lk_valid,
  output logic        lk_ready,
  input  lookup_t     lk,
  output index_t      rd_index,
  input  logic        rd_hit_valid,
  input  tag_t        rd_tag,
  input  line_t       rd_line,
  output logic        wr_en,
  output index_t      wr_index,
  output tag_t        wr_tag,
  output line_t       wr_line,
  output logic        flush,
  output logic        fill_req_valid,
  input  logic        fill_req_ready,
  output fill_req_t   fill_req,
  input  logic        fill_resp_valid,
  output logic        fill_resp_ready,
  input  fill_resp_t  fill_resp,
  output logic        rs_valid,
  input  logic        rs_ready,
  output fetch_resp_t rs
);

  typedef enum logic [2:0] {
    S_IDLE, S_READ, S_FILL_REQ, S_FILL_WAIT, S_WRITE, S_RESPOND
  } state_t;

  state_t  state;
  lookup_t cur;        // request being served
  line_t   resp_line;  // from the array on a hit, from the LLC on a miss
  logic    rd_wait;    // first READ cycle, array output not there yet
  logic    flush_q;
  logic    hit;
  logic    take_lookup;
  logic    fill_done;

  assign lk_ready    = (state == S_IDLE);
  assign take_lookup = lk_valid && lk_ready && !lk.flush;
  assign hit         = rd_hit_valid && (rd_tag == cur.tag);
  assign fill_done   = fill_resp_valid && fill_resp_ready;

  assign rd_index = cur.index;
  assign wr_en    = (state == S_WRITE);
  assign wr_index = cur.index;
  assign wr_tag   = cur.tag;
  assign wr_line  = resp_line;
  assign flush    = flush_q;

  assign fill_req_valid  = (state == S_FILL_REQ);
  assign fill_req        = '{addr: cur.addr};
  assign fill_resp_ready = (state == S_FILL_WAIT);  // only while a fill is outstanding

  assign rs_valid = (state == S_RESPOND);
  assign rs       = '{addr: cur.addr, line: resp_line};

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state   <= S_IDLE;
      rd_wait <= 1'b0;
      flush_q <= 1'b0;
    end else begin
      flush_q <= lk_valid && lk_ready && lk.flush;  // one-cycle strobe
      case (state)
        S_IDLE: begin
          if (take_lookup) begin
            state   <= S_READ;
            rd_wait <= 1'b1;
          end
        end
        S_READ: begin
          if (rd_wait) begin
            rd_wait <= 1'b0;
          end else begin
            state <= hit ? S_RESPOND : S_FILL_REQ;
          end
        end
        S_FILL_REQ:  if (fill_req_ready) state <= S_FILL_WAIT;
        S_FILL_WAIT: if (fill_done) state <= S_WRITE;
        S_WRITE:     state <= S_RESPOND;
        S_RESPOND:   if (rs_ready) state <= S_IDLE;
        default:     state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (take_lookup) begin
      cur <= lk;
    end
    if (state == S_READ && !rd_wait && hit) begin
      resp_line <= rd_line;
    end else if (fill_done) begin
      resp_line <= fill_resp.line;
    end
  end

endmodule : icache_lookup_ctrl

`default_nettype wire

// File: rtl/icache_resp_stage.sv
//**************************************************************************
// icache response register toward l0, holds under back-pressure
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module icache_resp_stage
  import icache_msg_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_N_in,
  input  logic        rs_valid,
  output logic        rs_ready,
  input  fetch_resp_t rs,
  output logic        fetch_resp_valid,
  input  logic        fetch_resp_ready,
  output fetch_resp_t fetch_resp
);

  logic        out_valid;
  fetch_resp_t out_q;

  // take a new line when empty or draining this cycle
  assign rs_ready = !out_valid || fetch_resp_ready;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      out_valid <= 1'b0;
    end else if (rs_ready) begin
      out_valid <= rs_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rs_valid && rs_ready) out_q <= rs;  // payload frozen otherwise
  end

  assign fetch_resp_valid = out_valid;
  assign fetch_resp       = out_q;

endmodule : icache_resp_stage

`default_nettype wire

// File: rtl/l1_instr_cache.sv
//**************************************************************************
// l1 instruction cache top: decode, lookup control, array, response stage
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module l1_instr_cache
  import icache_cfg_pkg::*, icache_msg_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_N_in,
  // from l0
  input  logic        fetch_req_valid,
  output logic        fetch_req_ready,
  input  fetch_req_t  fetch_req,
  input  logic        flush_valid,
  output logic        flush_ready,
  // to l0
  output logic        fetch_resp_valid,
  input  logic        fetch_resp_ready,
  output fetch_resp_t fetch_resp,
  // to and from the LLC
  output logic        fill_req_valid,
  input  logic        fill_req_ready,
  output fill_req_t   fill_req,
  input  logic        fill_resp_valid,
  output logic        fill_resp_ready,
  input  fill_resp_t  fill_resp
);

  logic        lk_valid, lk_ready;
  lookup_t     lk;
  index_t      rd_index, wr_index;
  logic        rd_hit_valid, wr_en, arr_flush;
  tag_t        rd_tag, wr_tag;
  line_t       rd_line, wr_line;
  logic        rs_valid, rs_ready;
  fetch_resp_t rs;

  icache_req_decode u_decode (
    .clk_in, .rst_N_in,
    .fetch_req_valid, .fetch_req_ready, .fetch_req,
    .flush_valid, .flush_ready,
    .lk_valid, .lk_ready, .lk
  );

  icache_lookup_ctrl u_ctrl (
    .clk_in, .rst_N_in,
    .lk_valid, .lk_ready, .lk,
    .rd_index, .rd_hit_valid, .rd_tag, .rd_line,
    .wr_en, .wr_index, .wr_tag, .wr_line,
    .flush (arr_flush),
    .fill_req_valid, .fill_req_ready, .fill_req,
    .fill_resp_valid, .fill_resp_ready, .fill_resp,
    .rs_valid, .rs_ready, .rs
  );

  icache_tag_data_array u_array (
    .clk_in, .rst_N_in,
    .rd_index, .rd_hit_valid, .rd_tag, .rd_line,
    .wr_en, .wr_index, .wr_tag, .wr_line,
    .flush (arr_flush)
  );

  icache_resp_stage u_resp (
    .clk_in, .rst_N_in,
    .rs_valid, .rs_ready, .rs,
    .fetch_resp_valid, .fetch_resp_ready, .fetch_resp
  );

endmodule : l1_instr_cache

`default_nettype wire

// File: test/icache_checker.sv
//**************************************************************************
// icache checker: reference valid/tag model, compares responses and fills
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module icache_checker
  import icache_cfg_pkg::*, icache_msg_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_N_in,
  input  logic        fetch_req_valid,
  input  logic        fetch_req_ready,
  input  fetch_req_t  fetch_req,
  input  logic        flush_valid,
  input  logic        flush_ready,
  input  logic        fetch_resp_valid,
  input  logic        fetch_resp_ready,
  input  fetch_resp_t fetch_resp,
  input  logic        fill_req_valid,
  input  logic        fill_req_ready,
  input  fill_req_t   fill_req,
  input  logic        fill_resp_valid,
  input  logic        fill_resp_ready,
  input  logic        drain_check,  // end of a test, everything must be answered
  output int          errors,
  output int          n_fetch,
  output int          n_resp,
  output int          n_fill,
  output int          n_flush,
  output int          n_lat,
  output logic        drained
);

  logic [SETS-1:0]   mv = '0;     // model valid bits
  tag_t              mt [SETS];   // model tags
  logic [ADDR_W-1:0] exp_q [$];   // line addresses of expected responses
  logic [ADDR_W-1:0] fill_q [$];  // line addresses of expected fills
  int                err = 0;
  int                nf = 0;
  int                nr = 0;
  int                nfl = 0;
  int                nfu = 0;
  int                nlat = 0;
  int                cyc = 0;
  int                t0 = 0;
  logic              timed = 1'b0;  // a hit is waiting for its 4-cycle response
  logic              fill_out = 1'b0;  // a fill is outstanding at the LLC
  logic              rst_prev = 1'b0;
  logic              hold_prev = 1'b0;
  fetch_resp_t       resp_prev;

  // each 32-bit word is the line address plus its byte offset
  function automatic line_t expected_line(input logic [ADDR_W-1:0] a);
    line_t l;
    for (int w = 0; w < LINE_BYTES / 4; w++) l[32*w +: 32] = a + 32'(4 * w);
    return l;
  endfunction

  assign drained = (n_resp == n_fetch);

  always @(posedge clk_in) begin : watch
    logic [ADDR_W-1:0] a;
    logic              hit;
    cyc++;
    if (!rst_N_in) begin
      mv = '0;
      exp_q.delete();
      fill_q.delete();
      timed    = 1'b0;
      fill_out = 1'b0;
    end else begin
      if (!rst_prev && (fetch_resp_valid || fill_req_valid || !fetch_req_ready ||
                        !flush_ready || fill_resp_ready)) begin
        $display("mismatch at %0t: handshake outputs not in their reset state", $time);
        err++;
      end
      if (hold_prev && (!fetch_resp_valid || fetch_resp != resp_prev)) begin
        $display("mismatch at %0t: held fetch response changed under back-pressure", $time);
        err++;
      end
      if (timed && fetch_resp_valid) begin
        nlat++;
        timed = 1'b0;
        if (cyc - 1 - t0 != 4) begin  // valid rose on the previous edge
          $display("mismatch at %0t: hit answered after %0d cycles, expected 4",
                   $time, cyc - 1 - t0);
          err++;
        end
      end
      if (fetch_resp_valid && fetch_resp_ready) begin
        nr++;
        if (exp_q.size() == 0) begin
          $display("error at %0t: fetch response with no fetch outstanding", $time);
          err++;
        end else begin
          a = exp_q.pop_front();
          if (fetch_resp.addr != a || fetch_resp.line != expected_line(a)) begin
            $display("mismatch at %0t: response %h/%h, expected %h/%h", $time,
                     fetch_resp.addr, fetch_resp.line, a, expected_line(a));
            err++;
          end
        end
      end
      // ready toward the LLC only while a fill is outstanding
      if (fill_resp_ready != fill_out) begin
        $display("mismatch at %0t: fill_resp_ready %0b, expected %0b", $time,
                 fill_resp_ready, fill_out);
        err++;
      end
      if (fill_resp_valid && fill_resp_ready) fill_out = 1'b0;
      if (fill_req_valid && fill_req_ready) begin
        nfl++;
        fill_out = 1'b1;
        if (fill_q.size() == 0) begin
          $display("error at %0t: fill request although the model has a hit", $time);
          err++;
        end else begin
          a = fill_q.pop_front();
          if (fill_req.addr != a) begin
            $display("mismatch at %0t: fill address %h, expected %h", $time,
                     fill_req.addr, a);
            err++;
          end
        end
      end
      if (flush_valid && flush_ready) begin
        mv = '0;
        nfu++;
      end
      if (fetch_req_valid && fetch_req_ready) begin
        nf++;
        a   = {fetch_req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        hit = mv[a[7:4]] && (mt[a[7:4]] == a[31:8]);
        if (!hit) begin
          fill_q.push_back(a);
          mv[a[7:4]] = 1'b1;
          mt[a[7:4]] = a[31:8];
        end else if (exp_q.size() == 0) begin  // nothing ahead in the cache
          timed = 1'b1;
          t0    = cyc;
        end
        exp_q.push_back(a);
      end
      if (drain_check && (exp_q.size() != 0 || fill_q.size() != 0 || nr != nf)) begin
        $display("error at %0t: %0d responses for %0d fetches, %0d fills still expected",
                 $time, nr, nf, fill_q.size());
        err++;
      end
    end
    rst_prev  = rst_N_in;
    hold_prev = rst_N_in && fetch_resp_valid && !fetch_resp_ready;
    resp_prev = fetch_resp;
    errors  <= err;
    n_fetch <= nf;
    n_resp  <= nr;
    n_fill  <= nfl;
    n_flush <= nfu;
    n_lat   <= nlat;
  end

endmodule : icache_checker

`default_nettype wire

// File: test/tb_l1_instr_cache.sv
//**************************************************************************
// l1 instruction cache testbench: random fetches, LLC model, watchdog
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_l1_instr_cache
  import icache_cfg_pkg::*, icache_msg_pkg::*;
();

  localparam logic [31:0] SEED = 32'ha59d_9ebb;
  localparam int N_RAND_A = 120;  // random fetches, no back-pressure
  localparam int N_RAND_B = 160;  // random fetches and flushes, back-pressure
  localparam int NUM_REQ  = N_RAND_A + N_RAND_B + 20;
  localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + 500;

  logic        clk_in, rst_N_in;
  logic        fetch_req_valid, fetch_req_ready, flush_valid, flush_ready;
  fetch_req_t  fetch_req;
  logic        fetch_resp_valid, fetch_resp_ready;
  fetch_resp_t fetch_resp;
  logic        fill_req_valid, fill_req_ready, fill_resp_valid, fill_resp_ready;
  fill_req_t   fill_req;
  fill_resp_t  fill_resp;
  logic        drain_check, drained, bp_on;
  int          errors, n_fetch, n_resp, n_fill, n_flush, n_lat;
  int          err_mark = 0;
  int          n_tests = 0;
  logic [31:0] stim_lfsr, rbp_lfsr, fbp_lfsr, dly_lfsr;  // one stream per process

  l1_instr_cache dut_i (.*);
  icache_checker chk_i (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      st = lfsr_next(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  function automatic line_t line_of(input logic [31:0] a);
    line_t l;
    for (int w = 0; w < 4; w++) l[32*w +: 32] = a + 32'(4 * w);
    return l;
  endfunction

  task automatic send_fetch(input logic [31:0] a);
    fetch_req_valid <= 1'b1;
    fetch_req       <= '{addr: a};
    @(posedge clk_in);
    while (!fetch_req_ready) @(posedge clk_in);
    fetch_req_valid <= 1'b0;
  endtask

  task automatic send_flush();
    flush_valid <= 1'b1;
    @(posedge clk_in);
    while (!flush_ready) @(posedge clk_in);
    flush_valid <= 1'b0;
  endtask

  task automatic run_random(input int count, input logic with_flush);
    logic [31:0] v;
    for (int i = 0; i < count; i++) begin
      draw_bits(stim_lfsr, 4, v);
      if (with_flush && v == 0) begin
        send_flush();
      end else begin
        draw_bits(stim_lfsr, 10, v);  // 4 tags x 16 sets x 16 offsets
        send_fetch({16'h0001, 6'h00, v[9:0]});
      end
      draw_bits(stim_lfsr, 2, v);
      repeat (v) @(posedge clk_in);
    end
  endtask

  task automatic finish_test(input string name);
    do @(posedge clk_in); while (!drained);
    drain_check <= 1'b1;
    @(posedge clk_in);
    drain_check <= 1'b0;
    repeat (2) @(posedge clk_in);
    $display("test %-14s done, %0d errors", name, errors - err_mark);
    err_mark = errors;
    n_tests++;
  endtask

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  // fetch_resp_ready, random low periods of 1 to 8 cycles
  initial begin : resp_backpressure
    logic [31:0] v;
    int          hold;
    hold = 0;
    forever begin
      @(posedge clk_in);
      if (bp_on && hold == 0) begin
        draw_bits(rbp_lfsr, 3, v);
        if (v == 0) begin
          draw_bits(rbp_lfsr, 3, v);
          hold = v + 1;
        end
      end
      fetch_resp_ready <= (hold == 0);
      if (hold > 0) hold--;
    end
  end

  initial begin : fill_backpressure
    logic [31:0] v;
    int          hold;
    hold = 0;
    forever begin
      @(posedge clk_in);
      if (bp_on && hold == 0) begin
        draw_bits(fbp_lfsr, 2, v);
        if (v == 0) begin
          draw_bits(fbp_lfsr, 2, v);
          hold = v + 1;
        end
      end
      fill_req_ready <= (hold == 0);
      if (hold > 0) hold--;
    end
  end

  // LLC model, one fill at a time, answer after 0 to 7 cycles
  initial begin : llc_model
    logic [31:0] a, d;
    forever begin
      @(posedge clk_in);
      if (fill_req_valid && fill_req_ready) begin
        a = fill_req.addr;
        draw_bits(dly_lfsr, 3, d);
        repeat (d) @(posedge clk_in);
        fill_resp_valid <= 1'b1;
        fill_resp       <= '{addr: a, line: line_of(a)};
        @(posedge clk_in);
        while (!fill_resp_ready) @(posedge clk_in);
        fill_resp_valid <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_in);
    $display("watchdog expired after %0d cycles, the DUT stopped answering", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    logic [31:0] v;
    rst_N_in         = 1'b0;
    fetch_req_valid  = 1'b0;
    fetch_req        = '0;
    flush_valid      = 1'b0;
    fetch_resp_ready = 1'b1;
    fill_req_ready   = 1'b1;
    fill_resp_valid  = 1'b0;
    fill_resp        = '0;
    drain_check      = 1'b0;
    bp_on            = 1'b0;
    stim_lfsr = SEED;
    rbp_lfsr  = SEED;
    fbp_lfsr  = SEED;
    dly_lfsr  = SEED;
    draw_bits(rbp_lfsr, 1000, v);  // spread the streams apart
    draw_bits(fbp_lfsr, 2000, v);
    draw_bits(dly_lfsr, 3000, v);
    repeat (16) @(posedge clk_in);
    rst_N_in <= 1'b1;
    finish_test("reset_state");
    send_fetch(32'h0001_0234);
    finish_test("first_miss");
    send_fetch(32'h0001_0238);  // same line, pipeline empty
    finish_test("hit_latency");
    run_random(N_RAND_A, 1'b0);
    finish_test("random_plain");
    for (int i = 0; i < 8; i++) send_fetch(32'h0001_0300 + 32'(16 * i));
    send_flush();
    for (int i = 0; i < 8; i++) send_fetch(32'h0001_0304 + 32'(16 * i));
    finish_test("flush_refetch");
    bp_on <= 1'b1;
    run_random(N_RAND_B, 1'b1);
    finish_test("random_backpr");
    $display("tests %0d, fetches %0d, responses %0d, fills %0d, flushes %0d, timed hits %0d, errors %0d",
             n_tests, n_fetch, n_resp, n_fill, n_flush, n_lat, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_l1_instr_cache

`default_nettype wire

// File: verilog.f
rtl/icache_cfg_pkg.sv
rtl/icache_msg_pkg.sv
rtl/icache_req_decode.sv
rtl/icache_tag_data_array.sv
rtl/icache_lookup_ctrl.sv
rtl/icache_resp_stage.sv
rtl/l1_instr_cache.sv
test/icache_checker.sv
test/tb_l1_instr_cache.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide by searching the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_l1_instr_cache -o tb_sim \
  > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log

grep -q "TB PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
